/* logic/plot_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Sizes, APB register map and derived widths for the column plot engine
// Used by scoped name from every design file, never imported
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package plot_pkg;

	// Screen geometry
	localparam int COLS    = 8;
	localparam int ROWS    = 16;
	localparam int ROW_W   = 4;
	localparam int COL_W   = 3;
	localparam int PIXEL_W = 8;

	// Frame buffer, one word per pixel, row major
	localparam int FB_DEPTH  = ROWS * COLS;
	localparam int FB_ADDR_W = 7;

	// APB bus widths
	localparam int APB_ADDR_W = 12;
	localparam int APB_DATA_W = 32;

	////////////////////////////////////////////////////////////////////////
	// Register map, byte offsets
	////////////////////////////////////////////////////////////////////////

	// Column select mask, read/write
	localparam logic [APB_ADDR_W-1:0] REG_COL_SELECT = 'h000;
	// Row index, read/write
	localparam logic [APB_ADDR_W-1:0] REG_ROW        = 'h004;
	// Pixel color, read/write
	localparam logic [APB_ADDR_W-1:0] REG_COLOR      = 'h008;
	// Column done mask, read only
	localparam logic [APB_ADDR_W-1:0] REG_COL_DONE   = 'h00C;
	// Frame buffer read window, word k is pixel k
	localparam logic [APB_ADDR_W-1:0] FB_WINDOW_BASE = 'h400;

endpackage

`default_nettype wire

/* logic/plot_ctrl_if.sv */
////////////////////////////////////////////////////////////////////////////
// Control group between the APB register block and the plot engine
////////////////////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/10ps

interface plot_ctrl_if;

	// One bit per column, set by software
	logic [plot_pkg::COLS-1:0]    col_select;
	// One bit per column, set when that column has plotted
	logic [plot_pkg::COLS-1:0]    col_done;
	// Target row and pixel value for the current pass
	logic [plot_pkg::ROW_W-1:0]   row;
	logic [plot_pkg::PIXEL_W-1:0] color;

	// Host side
	modport regs (output col_select, output row, output color, input col_done);

	// Column state machines
	modport plotters (input col_select, output col_done);

	// Pixel writer
	modport arbiter (input row, input color);

endinterface

`default_nettype wire

/* logic/frame_buffer.sv */
////////////////////////////////////////////////////////////////////////////
// Pixel memory, one write port and one registered read port
// Data appears one cycle after the read address
////////////////////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/10ps

module frame_buffer (
	input  logic                           CLOCK_50,
	input  logic                           fb_we,
	input  logic [plot_pkg::FB_ADDR_W-1:0] fb_waddr,
	input  logic [plot_pkg::PIXEL_W-1:0]   fb_wdata,
	input  logic [plot_pkg::FB_ADDR_W-1:0] fb_raddr,
	output logic [plot_pkg::PIXEL_W-1:0]   fb_rdata
);

	// One word per pixel
	logic [plot_pkg::PIXEL_W-1:0] mem [plot_pkg::FB_DEPTH];

	// Write port
	always_ff @(posedge CLOCK_50) begin
		if (fb_we)
			mem[fb_waddr] <= fb_wdata;
	end

	// Read port, old data on a same-address collision
	always_ff @(posedge CLOCK_50) begin
		fb_rdata <= mem[fb_raddr];
	end

endmodule

`default_nettype wire

/* logic/column_plotters.sv */
////////////////////////////////////////////////////////////////////////////
// Bank of per-column plotters, each asks the arbiter for one pixel write
// when selected and reports done until deselected
////////////////////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/10ps

module column_plotters (
	input  logic                      CLOCK_50,
	input  logic                      rst_n,
	plot_ctrl_if.plotters             ctrl,
	output logic [plot_pkg::COLS-1:0] plot_req,
	input  logic [plot_pkg::COLS-1:0] plot_ack
);

	// Idle, waiting for ack, done, waiting for deselect
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WAIT_ACK,
		ST_DONE,
		ST_WAIT_DESEL
	} plot_state_t;

	plot_state_t state_q [plot_pkg::COLS];

	////////////////////////////////////////////////////////////////////////
	// One state machine per column
	////////////////////////////////////////////////////////////////////////
	for (genvar i = 0; i < plot_pkg::COLS; i++) begin : g_col
		always_ff @(posedge CLOCK_50) begin
			if (!rst_n) begin
				state_q[i] <= ST_IDLE;
			end else begin
				case (state_q[i])
					ST_IDLE: begin
						// Select seen, raise request
						if (ctrl.col_select[i])
							state_q[i] <= ST_WAIT_ACK;
					end
					ST_WAIT_ACK: begin
						// Hold request until the write happens
						if (plot_ack[i])
							state_q[i] <= ST_DONE;
					end
					ST_DONE: begin
						state_q[i] <= ST_WAIT_DESEL;
					end
					ST_WAIT_DESEL: begin
						// Drop done once software clears the bit
						if (!ctrl.col_select[i])
							state_q[i] <= ST_IDLE;
					end
					default: begin
						state_q[i] <= ST_IDLE;
					end
				endcase
			end
		end
	end

	// Request and done straight from state
	always_comb begin
		for (int i = 0; i < plot_pkg::COLS; i++) begin
			plot_req[i]      = (state_q[i] == ST_WAIT_ACK);
			ctrl.col_done[i] = (state_q[i] == ST_WAIT_DESEL);
		end
	end

endmodule

`default_nettype wire

/* logic/pixel_arbiter.sv */
////////////////////////////////////////////////////////////////////////////
// Round-robin arbiter, one granted column per cycle becomes a frame
// buffer write; the clear walk takes the write port while busy
////////////////////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/10ps

module pixel_arbiter (
	input  logic                           CLOCK_50,
	input  logic                           rst_n,
	plot_ctrl_if.arbiter                   ctrl,
	input  logic [plot_pkg::COLS-1:0]      plot_req,
	output logic [plot_pkg::COLS-1:0]      plot_ack,
	input  logic                           clr_busy,
	input  logic [plot_pkg::FB_ADDR_W-1:0] clr_addr,
	output logic                           fb_we,
	output logic [plot_pkg::FB_ADDR_W-1:0] fb_waddr,
	output logic [plot_pkg::PIXEL_W-1:0]   fb_wdata
);

	logic                           grant_found;
	logic                           grant_valid;
	logic [plot_pkg::COL_W-1:0]     grant_col;
	logic [plot_pkg::COL_W-1:0]     rr_ptr;
	logic [plot_pkg::FB_ADDR_W-1:0] pix_addr;

	////////////////////////////////////////////////////////////////////////
	// Pick first requester at or after the pointer
	////////////////////////////////////////////////////////////////////////
	always_comb begin
		int unsigned idx;
		grant_found = 1'b0;
		grant_col   = '0;
		for (int i = 0; i < plot_pkg::COLS; i++) begin
			idx = (int'(rr_ptr) + i) % plot_pkg::COLS;
			if (!grant_found && plot_req[idx]) begin
				grant_found = 1'b1;
				grant_col   = plot_pkg::COL_W'(idx);
			end
		end
	end

	// Clear walk blocks all grants
	assign grant_valid = grant_found && !clr_busy;

	// Row major pixel address
	assign pix_addr = plot_pkg::FB_ADDR_W'(ctrl.row) * plot_pkg::FB_ADDR_W'(plot_pkg::COLS)
		+ plot_pkg::FB_ADDR_W'(grant_col);

	// Ack pulses in the write cycle
	always_comb begin
		plot_ack = '0;
		if (grant_valid)
			plot_ack[grant_col] = 1'b1;
	end

	// Write port mux
	always_comb begin
		if (clr_busy) begin
			fb_we    = 1'b1;
			fb_waddr = clr_addr;
			fb_wdata = '0;
		end else begin
			fb_we    = grant_valid;
			fb_waddr = pix_addr;
			fb_wdata = ctrl.color;
		end
	end

	// Pointer moves past the column just served
	always_ff @(posedge CLOCK_50) begin
		if (!rst_n)
			rr_ptr <= '0;
		else if (grant_valid)
			rr_ptr <= plot_pkg::COL_W'((int'(grant_col) + 1) % plot_pkg::COLS);
	end

endmodule

`default_nettype wire

/* logic/apb_plot_regs.sv */
////////////////////////////////////////////////////////////////////////////
// APB slave for the plot engine: control registers, done mask readback,
// frame buffer read window and the post-reset clear walk
////////////////////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/10ps

module apb_plot_regs (
	input  logic                              CLOCK_50,
	input  logic                              rst_n,
	input  logic                              psel,
	input  logic                              penable,
	input  logic                              pwrite,
	input  logic [plot_pkg::APB_ADDR_W-1:0]   paddr,
	input  logic [plot_pkg::APB_DATA_W-1:0]   pwdata,
	output logic [plot_pkg::APB_DATA_W-1:0]   prdata,
	output logic                              pready,
	output logic                              pslverr,
	plot_ctrl_if.regs                         ctrl,
	output logic [plot_pkg::FB_ADDR_W-1:0]    fb_raddr,
	input  logic [plot_pkg::PIXEL_W-1:0]      fb_rdata,
	output logic                              clr_busy,
	output logic [plot_pkg::FB_ADDR_W-1:0]    clr_addr
);

	logic                            access;
	logic                            is_sel;
	logic                            is_row;
	logic                            is_color;
	logic                            is_done;
	logic                            win_hit;
	logic                            win_in_range;
	logic                            win_read;
	logic                            err;
	logic                            rd_wait;
	logic                            clr_done;
	logic [plot_pkg::APB_ADDR_W-1:0] win_off;

	assign access = psel & penable;

	////////////////////////////////////////////////////////////////////////
	// Address decode
	////////////////////////////////////////////////////////////////////////
	always_comb begin
		is_sel       = (paddr == plot_pkg::REG_COL_SELECT);
		is_row       = (paddr == plot_pkg::REG_ROW);
		is_color     = (paddr == plot_pkg::REG_COLOR);
		is_done      = (paddr == plot_pkg::REG_COL_DONE);
		win_hit      = (paddr >= plot_pkg::FB_WINDOW_BASE);
		win_off      = paddr - plot_pkg::FB_WINDOW_BASE;
		// Word index past the last pixel is an error
		win_in_range = win_hit && (win_off[plot_pkg::APB_ADDR_W-1:2] < plot_pkg::FB_DEPTH);
		win_read     = !pwrite && win_in_range;
		// Done mask and window are read only
		if (pwrite)
			err = !(is_sel || is_row || is_color);
		else
			err = !(is_sel || is_row || is_color || is_done || win_in_range);
	end

	// Word address into the pixel memory
	assign fb_raddr = win_off[plot_pkg::FB_ADDR_W+1:2];

	// Zero waits for registers, one wait for the window, silent during the walk
	assign pready  = access && clr_done && (!win_read || rd_wait);
	assign pslverr = pready && err;

	// Wait state flag, memory data valid the cycle after it is set
	always_ff @(posedge CLOCK_50) begin
		if (!rst_n)
			rd_wait <= 1'b0;
		else
			rd_wait <= access && clr_done && win_read && !rd_wait;
	end

	// Control registers
	always_ff @(posedge CLOCK_50) begin
		if (!rst_n) begin
			ctrl.col_select <= '0;
			ctrl.row        <= '0;
			ctrl.color      <= '0;
		end else if (pready && pwrite && !err) begin
			if (is_sel)
				ctrl.col_select <= pwdata[plot_pkg::COLS-1:0];
			if (is_row)
				ctrl.row <= pwdata[plot_pkg::ROW_W-1:0];
			if (is_color)
				ctrl.color <= pwdata[plot_pkg::PIXEL_W-1:0];
		end
	end

	// Read mux, zero extended
	always_comb begin
		prdata = '0;
		if (is_sel)
			prdata[plot_pkg::COLS-1:0] = ctrl.col_select;
		else if (is_row)
			prdata[plot_pkg::ROW_W-1:0] = ctrl.row;
		else if (is_color)
			prdata[plot_pkg::PIXEL_W-1:0] = ctrl.color;
		else if (is_done)
			prdata[plot_pkg::COLS-1:0] = ctrl.col_done;
		else if (win_in_range)
			prdata[plot_pkg::PIXEL_W-1:0] = fb_rdata;
	end

	////////////////////////////////////////////////////////////////////////
	// Clear walk, one zero write per cycle over the whole memory
	////////////////////////////////////////////////////////////////////////
	always_ff @(posedge CLOCK_50) begin
		if (!rst_n) begin
			clr_busy <= 1'b0;
			clr_done <= 1'b0;
			clr_addr <= '0;
		end else if (clr_busy) begin
			clr_addr <= clr_addr + 1'b1;
			if (clr_addr == plot_pkg::FB_ADDR_W'(plot_pkg::FB_DEPTH - 1)) begin
				clr_busy <= 1'b0;
				clr_done <= 1'b1;
			end
		end else if (!clr_done) begin
			// Kick off once reset is released
			clr_busy <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* logic/dps_plot_top.sv */
////////////////////////////////////////////////////////////////////////////
// Plot engine top level with a plain APB slave port
////////////////////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/10ps

module dps_plot_top (
	input  logic                            CLOCK_50,
	input  logic                            rst_n,
	input  logic                            psel,
	input  logic                            penable,
	input  logic                            pwrite,
	input  logic [plot_pkg::APB_ADDR_W-1:0] paddr,
	input  logic [plot_pkg::APB_DATA_W-1:0] pwdata,
	output logic [plot_pkg::APB_DATA_W-1:0] prdata,
	output logic                            pready,
	output logic                            pslverr
);

	// Plotter handshake
	logic [plot_pkg::COLS-1:0]      plot_req;
	logic [plot_pkg::COLS-1:0]      plot_ack;

	// Clear walk
	logic                           clr_busy;
	logic [plot_pkg::FB_ADDR_W-1:0] clr_addr;

	// Memory ports
	logic                           fb_we;
	logic [plot_pkg::FB_ADDR_W-1:0] fb_waddr;
	logic [plot_pkg::PIXEL_W-1:0]   fb_wdata;
	logic [plot_pkg::FB_ADDR_W-1:0] fb_raddr;
	logic [plot_pkg::PIXEL_W-1:0]   fb_rdata;

	plot_ctrl_if ctrl ();

	////////////////////////////////////////////////////////////////////////
	// Blocks
	////////////////////////////////////////////////////////////////////////
	apb_plot_regs u_regs (
		.CLOCK_50 (CLOCK_50),
		.rst_n    (rst_n),
		.psel     (psel),
		.penable  (penable),
		.pwrite   (pwrite),
		.paddr    (paddr),
		.pwdata   (pwdata),
		.prdata   (prdata),
		.pready   (pready),
		.pslverr  (pslverr),
		.ctrl     (ctrl.regs),
		.fb_raddr (fb_raddr),
		.fb_rdata (fb_rdata),
		.clr_busy (clr_busy),
		.clr_addr (clr_addr)
	);

	column_plotters u_plotters (
		.CLOCK_50 (CLOCK_50),
		.rst_n    (rst_n),
		.ctrl     (ctrl.plotters),
		.plot_req (plot_req),
		.plot_ack (plot_ack)
	);

	pixel_arbiter u_arbiter (
		.CLOCK_50 (CLOCK_50),
		.rst_n    (rst_n),
		.ctrl     (ctrl.arbiter),
		.plot_req (plot_req),
		.plot_ack (plot_ack),
		.clr_busy (clr_busy),
		.clr_addr (clr_addr),
		.fb_we    (fb_we),
		.fb_waddr (fb_waddr),
		.fb_wdata (fb_wdata)
	);

	frame_buffer u_fb (
		.CLOCK_50 (CLOCK_50),
		.fb_we    (fb_we),
		.fb_waddr (fb_waddr),
		.fb_wdata (fb_wdata),
		.fb_raddr (fb_raddr),
		.fb_rdata (fb_rdata)
	);

endmodule

`default_nettype wire

/* verification/tb_dps_plot.sv */
////////////////////////////////////////////////////////////////////////////
// Drives the APB port of the plot engine top level and checks registers
// and the frame buffer window against a pixel model
////////////////////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/10ps

module tb_dps_plot;

	// Five window sweeps at about 4 cycles a word and 50 rounds of about 60
	// cycles stay well under this limit
	localparam int CYCLE_LIMIT = 20000;

	logic                            CLOCK_50;
	logic                            rst_n;
	logic                            psel;
	logic                            penable;
	logic                            pwrite;
	logic [plot_pkg::APB_ADDR_W-1:0] paddr;
	logic [plot_pkg::APB_DATA_W-1:0] pwdata;
	logic [plot_pkg::APB_DATA_W-1:0] prdata;
	logic                            pready;
	logic                            pslverr;

	// Expected pixels and register values
	logic [plot_pkg::PIXEL_W-1:0] fb_model [plot_pkg::FB_DEPTH];
	logic [plot_pkg::COLS-1:0]    sel_m;
	logic [plot_pkg::ROW_W-1:0]   row_m;
	logic [plot_pkg::PIXEL_W-1:0] color_m;
	int unsigned                  cycles = 0;

	dps_plot_top DUT (
		.CLOCK_50 (CLOCK_50),
		.rst_n    (rst_n),
		.psel     (psel),
		.penable  (penable),
		.pwrite   (pwrite),
		.paddr    (paddr),
		.pwdata   (pwdata),
		.prdata   (prdata),
		.pready   (pready),
		.pslverr  (pslverr)
	);

	// 8 ns clock
	initial begin
		CLOCK_50 = 1'b0;
		forever #4 CLOCK_50 = ~CLOCK_50;
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("** FAIL **");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic report_mismatch(input string msg);
		fail_run($sformatf("mismatch at %0t ns: %s", $time, msg));
	endtask

	// Watchdog
	always @(posedge CLOCK_50) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT)
			fail_run("timeout: the test did not finish within the cycle limit");
	end

	// Bus rules checked on every edge once out of reset
	always @(posedge CLOCK_50) begin
		if (rst_n) begin
			assert (!pslverr || pready)
				else report_mismatch("pslverr high without pready");
			assert (!pready || (psel && penable))
				else report_mismatch("pready high outside an access phase");
		end
	end

	////////////////////////////////////////////////////////////////////////
	// APB setup phase then access phase until pready
	////////////////////////////////////////////////////////////////////////
	task automatic apb_access(input logic write, input logic [plot_pkg::APB_ADDR_W-1:0] addr,
		input logic [plot_pkg::APB_DATA_W-1:0] wdata,
		output logic [plot_pkg::APB_DATA_W-1:0] rdata, output logic err);
		@(posedge CLOCK_50);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= write;
		paddr   <= addr;
		pwdata  <= wdata;
		@(posedge CLOCK_50);
		penable <= 1'b1;
		@(posedge CLOCK_50);
		// Stalls here through the clear walk and the window wait state
		while (!pready)
			@(posedge CLOCK_50);
		rdata = prdata;
		err   = pslverr;
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_write(input logic [plot_pkg::APB_ADDR_W-1:0] addr,
		input logic [plot_pkg::APB_DATA_W-1:0] wdata);
		logic [plot_pkg::APB_DATA_W-1:0] rdata;
		logic                            err;
		apb_access(1'b1, addr, wdata, rdata, err);
		assert (!err) else report_mismatch($sformatf("pslverr on write to 0x%03h", addr));
	endtask

	task automatic read_compare(input logic [plot_pkg::APB_ADDR_W-1:0] addr,
		input logic [plot_pkg::APB_DATA_W-1:0] expected);
		logic [plot_pkg::APB_DATA_W-1:0] rdata;
		logic                            err;
		apb_access(1'b0, addr, '0, rdata, err);
		assert (!err && rdata == expected)
			else report_mismatch($sformatf("read 0x%03h got 0x%08h err %0b, expected 0x%08h",
				addr, rdata, err, expected));
	endtask

	task automatic expect_slverr(input logic write, input logic [plot_pkg::APB_ADDR_W-1:0] addr);
		logic [plot_pkg::APB_DATA_W-1:0] rdata;
		logic                            err;
		apb_access(write, addr, 32'hFFFF_FFFF, rdata, err);
		assert (err)
			else report_mismatch($sformatf("no pslverr, write %0b to 0x%03h", write, addr));
	endtask

	// Poll the done mask until it equals the select mask
	// No unselected column may ever show done
	task automatic wait_done(input logic [plot_pkg::COLS-1:0] mask);
		logic [plot_pkg::APB_DATA_W-1:0] rdata;
		logic                            err;
		rdata = '1;
		while (rdata != plot_pkg::APB_DATA_W'(mask)) begin
			apb_access(1'b0, plot_pkg::REG_COL_DONE, '0, rdata, err);
			assert (!err && (rdata & ~plot_pkg::APB_DATA_W'(mask)) == 0)
				else report_mismatch($sformatf("done mask 0x%02h for select 0x%02h",
					rdata, mask));
		end
	endtask

	task automatic check_regs();
		read_compare(plot_pkg::REG_COL_SELECT, plot_pkg::APB_DATA_W'(sel_m));
		read_compare(plot_pkg::REG_ROW, plot_pkg::APB_DATA_W'(row_m));
		read_compare(plot_pkg::REG_COLOR, plot_pkg::APB_DATA_W'(color_m));
		read_compare(plot_pkg::REG_COL_DONE, '0);
	endtask

	task automatic check_window();
		for (int k = 0; k < plot_pkg::FB_DEPTH; k++)
			read_compare(plot_pkg::FB_WINDOW_BASE + plot_pkg::APB_ADDR_W'(4 * k),
				plot_pkg::APB_DATA_W'(fb_model[k]));
	endtask

	////////////////////////////////////////////////////////////////////////
	// One plot pass sets row and color, selects, waits for done, deselects
	////////////////////////////////////////////////////////////////////////
	task automatic plot_pass(input logic [plot_pkg::ROW_W-1:0] row,
		input logic [plot_pkg::PIXEL_W-1:0] color, input logic [plot_pkg::COLS-1:0] mask);
		apb_write(plot_pkg::REG_ROW, plot_pkg::APB_DATA_W'(row));
		apb_write(plot_pkg::REG_COLOR, plot_pkg::APB_DATA_W'(color));
		apb_write(plot_pkg::REG_COL_SELECT, plot_pkg::APB_DATA_W'(mask));
		row_m   = row;
		color_m = color;
		sel_m   = mask;
		wait_done(mask);
		read_compare(plot_pkg::REG_COL_SELECT, plot_pkg::APB_DATA_W'(mask));
		// Pixel index is row times columns plus column
		for (int c = 0; c < plot_pkg::COLS; c++)
			if (mask[c])
				fb_model[int'(row) * plot_pkg::COLS + c] = color;
		apb_write(plot_pkg::REG_COL_SELECT, '0);
		sel_m = '0;
		wait_done('0);
	endtask

	initial begin
		logic [plot_pkg::ROW_W-1:0]   rnd_row;
		logic [plot_pkg::PIXEL_W-1:0] rnd_color;
		logic [plot_pkg::COLS-1:0]    rnd_mask;
		void'($urandom(53));
		rst_n   <= 1'b0;
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		paddr   <= '0;
		pwdata  <= '0;
		foreach (fb_model[k])
			fb_model[k] = '0;
		sel_m   = '0;
		row_m   = '0;
		color_m = '0;
		repeat (2) @(posedge CLOCK_50);
		rst_n <= 1'b1;

		// Reset state
		// First read also waits out the clear walk
		check_regs();
		check_window();

		// Single column
		plot_pass(4'd5, 8'hA7, 8'h08);
		check_window();

		// All columns contend for the arbiter
		plot_pass(4'd9, 8'h3C, 8'hFF);
		check_window();

		// Reselect after clear rewrites the row
		plot_pass(4'd9, 8'hC3, 8'hFF);
		check_regs();
		check_window();

		// Error responses leave state alone
		expect_slverr(1'b0, 12'h010);
		expect_slverr(1'b1, 12'h010);
		expect_slverr(1'b1, 12'h3FC);
		expect_slverr(1'b1, plot_pkg::REG_COL_DONE);
		expect_slverr(1'b1, plot_pkg::FB_WINDOW_BASE);
		expect_slverr(1'b0, plot_pkg::FB_WINDOW_BASE + 12'(4 * plot_pkg::FB_DEPTH));
		expect_slverr(1'b0, 12'hFFC);
		check_regs();
		read_compare(plot_pkg::FB_WINDOW_BASE, plot_pkg::APB_DATA_W'(fb_model[0]));

		// Random rounds
		repeat (50) begin
			rnd_row   = plot_pkg::ROW_W'($urandom % plot_pkg::ROWS);
			rnd_color = plot_pkg::PIXEL_W'($urandom);
			rnd_mask  = plot_pkg::COLS'($urandom % 255 + 1);
			plot_pass(rnd_row, rnd_color, rnd_mask);
		end
		check_regs();
		check_window();

		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
logic/plot_pkg.sv
logic/plot_ctrl_if.sv
logic/frame_buffer.sv
logic/column_plotters.sv
logic/pixel_arbiter.sv
logic/apb_plot_regs.sv
logic/dps_plot_top.sv
verification/tb_dps_plot.sv
